// File: Makefile
TOP = game_control_tb

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --timescale 1ns/1ps --top-module $(TOP) -f game_control.f

sim:
	verilator --binary --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f game_control.f
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Testbench passed"

clean:
	rm -rf obj_dir

// File: bench/clock_gen.sv
`timescale 1ns/1ps

module clock_gen (
  output logic clk,
  output logic reset_n
);

  localparam int RESET_CYCLES = 8;

  initial begin
    clk = 1'b0;
    forever #20 clk = ~clk;  // 40 ns period
  end

  // release on a falling edge like the other inputs
  initial begin
    reset_n = 1'b0;
    repeat (RESET_CYCLES) @(posedge clk);
    @(negedge clk);
    reset_n = 1'b1;
  end

endmodule

// File: bench/game_control_checker.sv
`timescale 1ns/1ps

module game_control_checker import game_input_pkg::*; (
  input logic        clk,
  input logic        reset_n,
  input logic        credit,
  input credit_cnt_t credits,
  input queue_fill_t fill,
  input cmd_beat_t   cmd_out
);

  logic tripped;  // sticky, watched by the testbench

  initial tripped = 1'b0;

  reset_idle: assert property (@(posedge clk) !reset_n |=> !cmd_out.valid)
    else begin
      tripped = 1'b1;
      $error("cmd_out valid in the cycle after a reset cycle");
    end

  // out of credits and none returning, so no new beat
  no_credit_send: assert property (@(posedge clk) disable iff (!reset_n)
    credits == '0 && !credit |=> !cmd_out.valid)
    else begin
      tripped = 1'b1;
      $error("cmd_out valid with no credit left");
    end

  credit_bound: assert property (@(posedge clk) disable iff (!reset_n)
    credits <= credit_cnt_t'(CREDIT_MAX))
    else begin
      tripped = 1'b1;
      $error("credit counter above CREDIT_MAX");
    end

  fill_bound: assert property (@(posedge clk) disable iff (!reset_n)
    fill <= queue_fill_t'(QUEUE_DEPTH))
    else begin
      tripped = 1'b1;
      $error("queue fill count above QUEUE_DEPTH");
    end

endmodule

// File: bench/game_control_tb.sv
`timescale 1ns/1ps

module game_control_tb import game_input_pkg::*; ();

  localparam int EVENT_COUNT    = 120;  // 60 keys, 16 button, 28 mixed, 16 held
  localparam int EVENT_CYCLES   = 220;
  localparam int TIMEOUT_CYCLES = EVENT_COUNT * EVENT_CYCLES + 3600;
  localparam int KEPT_CMDS      = CREDIT_MAX + QUEUE_DEPTH;

  localparam logic [7:0] KEY_LETTERS [7] = '{"A", "D", "W", "S", "C", "X", "Z"};
  localparam game_cmd_t  KEY_CMDS [7] =
    '{CMD_LEFT, CMD_RIGHT, CMD_DOWN, CMD_DROP, CMD_HOLD, CMD_ROTATE, CMD_ROTATE_REV};
  localparam game_cmd_t  BTN_CMDS [BUTTON_COUNT] = '{CMD_RIGHT, CMD_HOLD, CMD_ROTATE, CMD_LEFT};

  logic                    clk;
  logic                    reset_n;
  logic [BUTTON_COUNT-1:0] usr_btn;
  logic                    uart_rx;
  logic                    credit;
  cmd_beat_t               cmd_out;

  game_cmd_t   expected [$];
  int          credit_due [$];  // cycle when each credit goes back
  logic        hold_credits;
  int          cycle;
  int          beats_seen;
  logic [31:0] rng_state;

  clock_gen clock_i (.*);
  game_control dut_i (.*);
  bind command_queue game_control_checker checker_i (.*);

  function automatic logic [31:0] next_random();
    rng_state ^= rng_state << 13;
    rng_state ^= rng_state >> 17;
    rng_state ^= rng_state << 5;
    return rng_state;
  endfunction

  function automatic int pick(int n);
    return int'(next_random() % 32'(n));
  endfunction

  // fold to upper case, then look the letter up
  function automatic game_cmd_t key_command(logic [7:0] key);
    logic [7:0] upper;
    upper = (key >= "a" && key <= "z") ? key - 8'h20 : key;
    for (int i = 0; i < 7; i++)
      if (KEY_LETTERS[i] == upper)
        return KEY_CMDS[i];
    return CMD_NONE;
  endfunction

  function automatic logic [7:0] random_letter();
    return KEY_LETTERS[pick(7)] | (pick(2) == 1 ? 8'h20 : 8'h00);  // either case
  endfunction

  task automatic abort_run(string why);
    $display("%s", why);
    $display("Testbench failed");
    $fatal(1);
  endtask

  task automatic check_value(string name, logic [31:0] got, logic [31:0] want);
    if (got !== want)
      abort_run($sformatf("ERROR at %0t: %s is %0d, expected %0d", $time, name, got, want));
  endtask

  // 8N1 frame lsb first, then a random idle gap
  task automatic send_key(logic [7:0] key, logic keep);
    logic [9:0] frame;
    frame = {1'b1, key, 1'b0};
    if (keep && key_command(key) != CMD_NONE)
      expected.push_back(key_command(key));
    for (int i = 0; i < 10; i++) begin
      uart_rx = frame[i];
      repeat (CLKS_PER_BIT) @(negedge clk);
    end
    repeat (4 + pick(20)) @(negedge clk);
  endtask

  // bounce pulses too short to pass, then maybe a real press and release
  task automatic press_button(int idx, int bounces, logic real_press);
    for (int b = 0; b < bounces; b++) begin
      usr_btn[idx] = 1'b1;
      repeat (1 + pick(DEBOUNCE_CYCLES - 2)) @(negedge clk);
      usr_btn[idx] = 1'b0;
      repeat (1 + pick(4)) @(negedge clk);
    end
    if (real_press) begin
      expected.push_back(BTN_CMDS[idx]);
      usr_btn[idx] = 1'b1;
      repeat (DEBOUNCE_CYCLES + 8) @(negedge clk);
      usr_btn[idx] = 1'b0;
    end
    repeat (DEBOUNCE_CYCLES + 8) @(negedge clk);
  endtask

  task automatic wait_drained();
    while (expected.size() != 0 || credit_due.size() != 0)
      @(negedge clk);
    repeat (4) @(negedge clk);  // last credit lands in the counter
  endtask

  // engine model checks each beat and returns its credit 0 to 7 cycles later
  always @(negedge clk) begin
    cycle++;
    credit = 1'b0;
    if (cycle >= TIMEOUT_CYCLES)
      abort_run($sformatf("timeout after %0d cycles, the run did not finish", cycle));
    if (dut_i.queue_i.checker_i.tripped)
      abort_run("a credit protocol assertion failed in the command queue");
    if (cmd_out.valid === 1'b1) begin
      if (!reset_n)
        abort_run("cmd_out valid while reset is held");
      else if (expected.size() == 0)
        abort_run("cmd_out valid with no command left to expect");
      else begin
        check_value("cmd_out.cmd", 32'(cmd_out.cmd), 32'(expected.pop_front()));
        beats_seen++;
        credit_due.push_back(cycle + pick(8));
      end
    end
    if (!hold_credits && credit_due.size() != 0 && credit_due[0] <= cycle) begin
      credit = 1'b1;
      void'(credit_due.pop_front());
    end
  end

  initial begin
    rng_state    = 32'hafe4_379b;
    usr_btn      = '0;
    uart_rx      = 1'b1;
    credit       = 1'b0;
    hold_credits = 1'b0;
    @(posedge reset_n);
    @(negedge clk);

    // letters in both cases with arbitrary bytes in between
    for (int i = 0; i < 60; i++)
      send_key(pick(4) == 0 ? 8'(next_random()) : random_letter(), 1'b1);

    for (int i = 0; i < 12; i++)
      press_button(i % BUTTON_COUNT, pick(4), 1'b1);
    for (int i = 0; i < BUTTON_COUNT; i++)
      press_button(i, 1 + pick(3), 1'b0);  // bounce alone
    wait_drained();

    for (int i = 0; i < 28; i++) begin
      if (pick(2) == 0)
        send_key(random_letter(), 1'b1);
      else
        press_button(pick(BUTTON_COUNT), pick(3), 1'b1);
      repeat (pick(10)) @(negedge clk);
    end
    wait_drained();

    // engine stalls, queue fills and then drops
    hold_credits = 1'b1;
    beats_seen   = 0;
    for (int i = 0; i < KEPT_CMDS + 4; i++)
      send_key(random_letter(), i < KEPT_CMDS);
    check_value("beats_seen", beats_seen, CREDIT_MAX);
    hold_credits = 1'b0;
    wait_drained();

    repeat (50) @(negedge clk);  // no stray beat may follow
    if (dut_i.queue_i.checker_i.tripped)
      abort_run("a credit protocol assertion failed in the command queue");
    else begin
      $display("Testbench passed");
      $finish;
    end
  end

endmodule

// File: game_control.f
source/game_input_pkg.sv
source/uart_rx.sv
source/key_debouncer.sv
source/command_arbiter.sv
source/command_queue.sv
source/game_control.sv
bench/clock_gen.sv
bench/game_control_checker.sv
bench/game_control_tb.sv

// File: source/command_arbiter.sv
`timescale 1ns/1ps

module command_arbiter import game_input_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,
  input  rx_beat_t                rx_beat,
  input  logic [BUTTON_COUNT-1:0] levels,
  output cmd_beat_t               cmd
);

  logic [BUTTON_COUNT-1:0] levels_q;
  logic [BUTTON_COUNT-1:0] pending;
  logic [BUTTON_COUNT-1:0] btn_grant;
  logic [BUTTON_COUNT-1:0] rise;
  game_cmd_t               btn_cmd;
  game_cmd_t               key_cmd;
  logic                    key_hit;

  // letters in either case, anything else is no command
  function automatic game_cmd_t decode_key(rx_byte_t key);
    case (key)
      "A", "a": return CMD_LEFT;
      "D", "d": return CMD_RIGHT;
      "W", "w": return CMD_DOWN;
      "S", "s": return CMD_DROP;
      "C", "c": return CMD_HOLD;
      "X", "x": return CMD_ROTATE;
      "Z", "z": return CMD_ROTATE_REV;
      default:  return CMD_NONE;
    endcase
  endfunction

  assign key_cmd = decode_key(rx_beat.data);
  assign key_hit = rx_beat.valid && (key_cmd != CMD_NONE);
  assign rise    = levels & ~levels_q;

  // lowest pending index wins
  always_comb begin
    btn_grant = '0;
    btn_cmd   = CMD_NONE;
    for (int i = BUTTON_COUNT - 1; i >= 0; i--) begin
      if (pending[i]) begin
        btn_grant    = '0;
        btn_grant[i] = 1'b1;
        btn_cmd      = BUTTON_CMD[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      levels_q  <= '0;
      pending   <= '0;
      cmd.valid <= 1'b0;
    end else begin
      levels_q  <= levels;
      // key byte takes the slot, buttons wait
      pending   <= (pending & ~(key_hit ? '0 : btn_grant)) | rise;
      cmd.valid <= key_hit || (|pending);
    end
  end

  always_ff @(posedge clk) begin
    cmd.cmd <= key_hit ? key_cmd : btn_cmd;
  end

endmodule

// File: source/command_queue.sv
`timescale 1ns/1ps

module command_queue import game_input_pkg::*; (
  input  logic      clk,
  input  logic      reset_n,
  input  cmd_beat_t cmd_in,
  input  logic      credit,
  output cmd_beat_t cmd_out
);

  game_cmd_t   mem [QUEUE_DEPTH];
  queue_ptr_t  wr_ptr;
  queue_ptr_t  rd_ptr;
  queue_fill_t fill;
  credit_cnt_t credits;

  logic empty;
  logic full;
  logic can_send;
  logic pop;
  logic bypass;
  logic push;
  logic send;

  assign empty    = (fill == '0);
  assign full     = (fill == queue_fill_t'(QUEUE_DEPTH));
  assign can_send = (credits != '0);
  assign pop      = can_send && !empty;
  // empty queue hands a new command straight to the output stage
  assign bypass   = can_send && empty && cmd_in.valid;
  assign push     = cmd_in.valid && !full && !bypass;  // full drops it
  assign send     = pop || bypass;

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      wr_ptr        <= '0;
      rd_ptr        <= '0;
      fill          <= '0;
      credits       <= credit_cnt_t'(CREDIT_MAX);
      cmd_out.valid <= 1'b0;
    end else begin
      if (push)
        wr_ptr <= wr_ptr + 1'b1;  // wraps at depth
      if (pop)
        rd_ptr <= rd_ptr + 1'b1;
      fill          <= fill + queue_fill_t'(push) - queue_fill_t'(pop);
      // returned credit and a send in one cycle cancel
      credits       <= credits + credit_cnt_t'(credit) - credit_cnt_t'(send);
      cmd_out.valid <= send;
    end
  end

  always_ff @(posedge clk) begin
    if (push)
      mem[wr_ptr] <= cmd_in.cmd;
  end

  always_ff @(posedge clk) begin
    if (send)
      cmd_out.cmd <= pop ? mem[rd_ptr] : cmd_in.cmd;
  end

endmodule

// File: source/game_control.sv
`timescale 1ns/1ps

module game_control import game_input_pkg::*; (
  input  logic                    clk,
  input  logic                    reset_n,
  input  logic [BUTTON_COUNT-1:0] usr_btn,
  input  logic                    uart_rx,
  input  logic                    credit,
  output cmd_beat_t               cmd_out
);

  rx_beat_t                rx_beat;
  logic [BUTTON_COUNT-1:0] levels;
  cmd_beat_t               arb_cmd;

  uart_rx rx_i (
    .clk     (clk),
    .reset_n (reset_n),
    .rx      (uart_rx),
    .beat    (rx_beat)
  );

  // one debouncer per button pin
  for (genvar i = 0; i < BUTTON_COUNT; i++) begin : g_btn
    key_debouncer debouncer_i (
      .clk     (clk),
      .reset_n (reset_n),
      .pin     (usr_btn[i]),
      .level   (levels[i])
    );
  end

  command_arbiter arbiter_i (
    .clk     (clk),
    .reset_n (reset_n),
    .rx_beat (rx_beat),
    .levels  (levels),
    .cmd     (arb_cmd)
  );

  command_queue queue_i (
    .clk     (clk),
    .reset_n (reset_n),
    .cmd_in  (arb_cmd),
    .credit  (credit),
    .cmd_out (cmd_out)
  );

endmodule

// File: source/game_input_pkg.sv
package game_input_pkg;

  // command codes toward the game engine
  typedef logic [2:0] game_cmd_t;

  localparam game_cmd_t CMD_NONE       = 3'd0;
  localparam game_cmd_t CMD_LEFT       = 3'd1;
  localparam game_cmd_t CMD_RIGHT      = 3'd2;
  localparam game_cmd_t CMD_DOWN       = 3'd3;
  localparam game_cmd_t CMD_DROP       = 3'd4;
  localparam game_cmd_t CMD_HOLD       = 3'd5;
  localparam game_cmd_t CMD_ROTATE     = 3'd6;
  localparam game_cmd_t CMD_ROTATE_REV = 3'd7;

  localparam int CLKS_PER_BIT    = 16;  // far more on a real board
  localparam int DEBOUNCE_CYCLES = 8;
  localparam int QUEUE_DEPTH     = 8;
  localparam int CREDIT_MAX      = 4;   // command slots in the engine
  localparam int BUTTON_COUNT    = 4;

  // button index to command
  localparam game_cmd_t BUTTON_CMD [BUTTON_COUNT] =
    '{CMD_RIGHT, CMD_HOLD, CMD_ROTATE, CMD_LEFT};

  typedef logic [7:0] rx_byte_t;

  typedef logic [$clog2(CLKS_PER_BIT)-1:0]    bit_timer_t;
  typedef logic [3:0]                         bit_index_t;  // start, 8 data, stop
  typedef logic [$clog2(DEBOUNCE_CYCLES)-1:0] debounce_cnt_t;
  typedef logic [$clog2(QUEUE_DEPTH)-1:0]     queue_ptr_t;
  typedef logic [$clog2(QUEUE_DEPTH+1)-1:0]   queue_fill_t;
  typedef logic [$clog2(CREDIT_MAX+1)-1:0]    credit_cnt_t;

  typedef struct packed {
    logic     valid;
    rx_byte_t data;
  } rx_beat_t;

  typedef struct packed {
    logic      valid;
    game_cmd_t cmd;
  } cmd_beat_t;

endpackage

// File: source/key_debouncer.sv
`timescale 1ns/1ps

module key_debouncer import game_input_pkg::*; (
  input  logic clk,
  input  logic reset_n,
  input  logic pin,
  output logic level
);

  logic [1:0]    pin_sync;
  debounce_cnt_t count;

  wire pin_s = pin_sync[1];

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      pin_sync <= '0;
      count    <= '0;
      level    <= 1'b0;
    end else begin
      pin_sync <= {pin_sync[0], pin};
      if (pin_s == level) begin
        count <= '0;  // bounce back restarts
      end else if (count == debounce_cnt_t'(DEBOUNCE_CYCLES - 1)) begin
        level <= pin_s;
        count <= '0;
      end else begin
        count <= count + 1'b1;
      end
    end
  end

endmodule

// File: source/uart_rx.sv
`timescale 1ns/1ps

module uart_rx import game_input_pkg::*; (
  input  logic     clk,
  input  logic     reset_n,
  input  logic     rx,
  output rx_beat_t beat
);

  logic [1:0] rx_sync;
  logic       rx_prev;
  logic       busy;
  bit_timer_t timer;
  bit_index_t bit_idx;
  logic       valid_q;
  rx_byte_t   shift;

  wire rx_s       = rx_sync[1];
  wire sample_now = busy && (timer == '0);

  assign beat = '{valid: valid_q, data: shift};

  always_ff @(posedge clk) begin
    if (!reset_n) begin
      rx_sync <= 2'b11;  // line idles high
      rx_prev <= 1'b1;
      busy    <= 1'b0;
      timer   <= '0;
      bit_idx <= '0;
      valid_q <= 1'b0;
    end else begin
      rx_sync <= {rx_sync[0], rx};
      rx_prev <= rx_s;
      valid_q <= 1'b0;
      if (!busy) begin
        if (rx_prev && !rx_s) begin
          // wait half a bit to land mid start bit
          busy    <= 1'b1;
          timer   <= bit_timer_t'(CLKS_PER_BIT / 2 - 1);
          bit_idx <= '0;
        end
      end else if (timer != '0) begin
        timer <= timer - 1'b1;
      end else begin
        timer   <= bit_timer_t'(CLKS_PER_BIT - 1);
        bit_idx <= bit_idx + 1'b1;
        if (bit_idx == '0) begin
          if (rx_s)
            busy <= 1'b0;  // start bit gone, just a glitch
        end else if (bit_idx == bit_index_t'(9)) begin
          busy    <= 1'b0;
          valid_q <= rx_s;  // low stop bit drops the byte
        end
      end
    end
  end

  // data bits arrive lsb first
  always_ff @(posedge clk) begin
    if (sample_now && bit_idx != '0 && bit_idx != bit_index_t'(9))
      shift <= {rx_s, shift[7:1]};
  end

endmodule
